/* logic/npu_consts.svh */
`ifndef NPU_CONSTS_SVH
`define NPU_CONSTS_SVH

// ------------------------------------------------------------
// word layout
// ------------------------------------------------------------
`define NPU_LANES      8
`define NPU_LANE_W     8
`define NPU_WORD_W     64

// ------------------------------------------------------------
// scratchpad geometry
// ------------------------------------------------------------
`define NPU_NUM_BANKS  4
`define NPU_BANK_W     2
// 64 words per bank
`define NPU_ADDR_W     6
// one extra bit so a full bank (64) fits
`define NPU_COUNT_W    7
// loader, eltwise engine, streamer
`define NPU_NUM_PORTS  3

`endif

/* logic/npu_pkg.sv */
`include "npu_consts.svh"

package npu_pkg;

    typedef logic signed [`NPU_LANE_W-1:0] lane_t;

    // lane 0 sits in the low byte
    typedef lane_t [`NPU_LANES-1:0] lane_vec_t;

    typedef struct packed {
        logic [`NPU_BANK_W-1:0] bank;
        logic [`NPU_ADDR_W-1:0] word;
    } spad_addr_t;

    typedef struct packed {
        logic       we;
        spad_addr_t addr;
        lane_vec_t  wdata;
    } mem_req_t;

    typedef struct packed {
        lane_vec_t  data;
        spad_addr_t dest;
    } in_beat_t;

    typedef struct packed {
        lane_vec_t data;
        logic      last;
    } out_beat_t;

    typedef enum logic [1:0] {
        OP_ADD,
        OP_SUB,
        OP_MUL
    } eltwise_op_e;

    // count is in words, element i at word i of each bank
    typedef struct packed {
        eltwise_op_e             op;
        logic [`NPU_BANK_W-1:0]  src_a;
        logic [`NPU_BANK_W-1:0]  src_b;
        logic [`NPU_BANK_W-1:0]  dst;
        logic [`NPU_COUNT_W-1:0] count;
    } op_cmd_t;

    typedef struct packed {
        logic [`NPU_BANK_W-1:0]  bank;
        logic [`NPU_COUNT_W-1:0] count;
    } out_cmd_t;

    typedef enum logic [1:0] {
        PORT_LOAD,
        PORT_ELTWISE,
        PORT_STREAM
    } port_e;

endpackage

/* logic/axis_reg_slice.sv */
`timescale 1ns/10ps

module axis_reg_slice #(
    parameter type payload_t = logic [63:0]
) (
    input  logic     s00_axis_aclk,
    input  logic     arst_n_i,
    input  logic     in_valid_i,
    input  payload_t in_data_i,
    output logic     in_ready_o,
    output logic     out_valid_o,
    output payload_t out_data_o,
    input  logic     out_ready_i
);

    // low until the first edge out of reset
    logic run_q;

    // a held item leaving frees the slot on the same edge
    assign in_ready_o = run_q && (!out_valid_o || out_ready_i);

    always_ff @(posedge s00_axis_aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            run_q       <= 1'b0;
            out_valid_o <= 1'b0;
        end else begin
            run_q <= 1'b1;
            if (in_ready_o) begin
                out_valid_o <= in_valid_i;
            end
        end
    end

    always_ff @(posedge s00_axis_aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_data_o <= '0;
        end else if (in_valid_i && in_ready_o) begin
            out_data_o <= in_data_i;
        end
    end

    hold_under_stall: assert property (@(posedge s00_axis_aclk) disable iff (!arst_n_i)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o));

endmodule

/* logic/scratchpad_arbiter.sv */
`timescale 1ns/10ps
`include "npu_consts.svh"

module scratchpad_arbiter import npu_pkg::*; (
    input  logic                      s00_axis_aclk,
    input  logic                      arst_n_i,
    input  logic [`NPU_NUM_PORTS-1:0] req_valid_i,
    input  mem_req_t                  req_i [`NPU_NUM_PORTS],
    output logic [`NPU_NUM_PORTS-1:0] gnt_o,
    output logic [`NPU_NUM_PORTS-1:0] rvalid_o,
    output lane_vec_t                 rdata_o
);

    localparam int DEPTH = `NPU_NUM_BANKS * (1 << `NPU_ADDR_W);

    // all banks in one array, indexed by {bank, word}
    lane_vec_t mem_q [DEPTH];
    port_e     last_q;
    port_e     gnt_idx;
    logic      gnt_any;
    mem_req_t  sel_req;

    // ------------------------------------------------------------
    // round robin, search starts after the last winner
    // ------------------------------------------------------------
    always_comb begin
        int cand;
        gnt_o   = '0;
        gnt_idx = PORT_LOAD;
        for (int k = 1; k <= `NPU_NUM_PORTS; k++) begin
            cand = (int'(last_q) + k) % `NPU_NUM_PORTS;
            if (gnt_o == '0 && req_valid_i[cand]) begin
                gnt_o[cand] = 1'b1;
                gnt_idx     = port_e'(cand);
            end
        end
    end

    assign gnt_any = |gnt_o;
    assign sel_req = req_i[gnt_idx];

    always_ff @(posedge s00_axis_aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            last_q   <= PORT_STREAM;
            rvalid_o <= '0;
        end else begin
            rvalid_o <= sel_req.we ? '0 : gnt_o;
            if (gnt_any) begin
                last_q <= gnt_idx;
            end
        end
    end

    // ------------------------------------------------------------
    // memory access, read data lands one cycle after the grant
    // ------------------------------------------------------------
    always_ff @(posedge s00_axis_aclk) begin
        if (gnt_any) begin
            if (sel_req.we) begin
                mem_q[sel_req.addr] <= sel_req.wdata;
            end else begin
                rdata_o <= mem_q[sel_req.addr];
            end
        end
    end

    gnt_onehot: assert property (@(posedge s00_axis_aclk) disable iff (!arst_n_i)
        $onehot0(gnt_o));

    gnt_to_requester: assert property (@(posedge s00_axis_aclk) disable iff (!arst_n_i)
        (gnt_o & ~req_valid_i) == '0);

endmodule

/* logic/stream_loader.sv */
`timescale 1ns/10ps
`include "npu_consts.svh"

module stream_loader import npu_pkg::*; (
    input  logic     s00_axis_aclk,
    input  logic     arst_n_i,
    input  logic     beat_valid_i,
    input  in_beat_t beat_i,
    output logic     beat_ready_o,
    output logic     req_valid_o,
    output mem_req_t req_o,
    input  logic     gnt_i
);

    // one write per beat, destination taken from the user field
    assign req_valid_o = beat_valid_i;

    always_comb begin
        req_o.we    = 1'b1;
        req_o.addr  = beat_i.dest;
        req_o.wdata = beat_i.data;
    end

    // the beat is popped exactly when its write is granted
    assign beat_ready_o = gnt_i;

    // stall from the arbiter must not disturb a pending write
    req_held: assert property (@(posedge s00_axis_aclk) disable iff (!arst_n_i)
        req_valid_o && !gnt_i |=> req_valid_o && $stable(req_o));

endmodule

/* logic/eltwise_engine.sv */
`timescale 1ns/10ps
`include "npu_consts.svh"

module eltwise_engine import npu_pkg::*; (
    input  logic      s00_axis_aclk,
    input  logic      arst_n_i,
    input  logic      cmd_valid_i,
    input  op_cmd_t   cmd_i,
    output logic      cmd_ready_o,
    output logic      done_o,
    output logic      req_valid_o,
    output mem_req_t  req_o,
    input  logic      gnt_i,
    input  logic      rvalid_i,
    input  lane_vec_t rdata_i
);

    typedef enum logic [1:0] {
        PH_RD_A,
        PH_RD_B,
        PH_WR
    } phase_e;

    op_cmd_t                 cmd_q;
    phase_e                  phase_q;
    logic                    busy_q;
    logic                    pend_b_q;
    logic                    res_ok_q;
    logic [`NPU_COUNT_W-1:0] rd_idx_q;
    logic [`NPU_ADDR_W-1:0]  wr_addr;
    lane_vec_t               a_q;
    lane_vec_t               res_q;

    // ------------------------------------------------------------
    // lane math with int8 saturation
    // ------------------------------------------------------------
    function automatic lane_vec_t lane_math(eltwise_op_e op, lane_vec_t a, lane_vec_t b);
        lane_vec_t          r;
        logic signed [16:0] wide;
        for (int l = 0; l < `NPU_LANES; l++) begin
            case (op)
                OP_ADD:  wide = $signed(a[l]) + $signed(b[l]);
                OP_SUB:  wide = $signed(a[l]) - $signed(b[l]);
                OP_MUL:  wide = $signed(a[l]) * $signed(b[l]);
                default: wide = $signed(a[l]);
            endcase
            if (wide > 17'sd127) begin
                r[l] = 8'h7f;
            end else if (wide < -17'sd128) begin
                r[l] = 8'h80;
            end else begin
                r[l] = wide[7:0];
            end
        end
        return r;
    endfunction

    // result of element i-1 is written once element i has been read
    assign wr_addr     = rd_idx_q[`NPU_ADDR_W-1:0] - 1'b1;
    assign cmd_ready_o = !busy_q;
    assign req_valid_o = busy_q && (phase_q != PH_WR || res_ok_q);

    always_comb begin
        req_o = '0;
        case (phase_q)
            PH_RD_A: begin
                req_o.addr = '{bank: cmd_q.src_a, word: rd_idx_q[`NPU_ADDR_W-1:0]};
            end
            PH_RD_B: begin
                req_o.addr = '{bank: cmd_q.src_b, word: rd_idx_q[`NPU_ADDR_W-1:0]};
            end
            default: begin
                req_o.we    = 1'b1;
                req_o.addr  = '{bank: cmd_q.dst, word: wr_addr};
                req_o.wdata = res_q;
            end
        endcase
    end

    // ------------------------------------------------------------
    // sequencing: A0 B0 A1 W0 B1 A2 W1 ... Bn-1 Wn-1
    // ------------------------------------------------------------
    always_ff @(posedge s00_axis_aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q   <= 1'b0;
            done_o   <= 1'b0;
            phase_q  <= PH_RD_A;
            rd_idx_q <= '0;
            pend_b_q <= 1'b0;
            res_ok_q <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (cmd_valid_i && cmd_ready_o) begin
                busy_q   <= 1'b1;
                phase_q  <= PH_RD_A;
                rd_idx_q <= '0;
                res_ok_q <= 1'b0;
            end
            if (rvalid_i && pend_b_q) begin
                res_ok_q <= 1'b1;
            end
            if (req_valid_o && gnt_i) begin
                pend_b_q <= (phase_q == PH_RD_B);
                case (phase_q)
                    PH_RD_A: begin
                        phase_q <= (rd_idx_q != '0) ? PH_WR : PH_RD_B;
                    end
                    PH_RD_B: begin
                        rd_idx_q <= rd_idx_q + 1'b1;
                        res_ok_q <= 1'b0;
                        phase_q  <= (rd_idx_q + 1'b1 == cmd_q.count) ? PH_WR : PH_RD_A;
                    end
                    default: begin
                        if (rd_idx_q == cmd_q.count) begin
                            busy_q <= 1'b0;
                            done_o <= 1'b1;
                        end else begin
                            phase_q <= PH_RD_B;
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge s00_axis_aclk) begin
        if (cmd_valid_i && cmd_ready_o) begin
            cmd_q <= cmd_i;
        end
        if (rvalid_i) begin
            if (pend_b_q) begin
                res_q <= lane_math(cmd_q.op, a_q, rdata_i);
            end else begin
                a_q <= rdata_i;
            end
        end
    end

    // read data only ever answers a read granted to this port
    rvalid_after_read: assert property (@(posedge s00_axis_aclk) disable iff (!arst_n_i)
        rvalid_i |-> $past(req_valid_o && gnt_i && !req_o.we));

endmodule

/* logic/result_streamer.sv */
`timescale 1ns/10ps
`include "npu_consts.svh"

module result_streamer import npu_pkg::*; (
    input  logic      s00_axis_aclk,
    input  logic      arst_n_i,
    input  logic      cmd_valid_i,
    input  out_cmd_t  cmd_i,
    output logic      cmd_ready_o,
    output logic      req_valid_o,
    output mem_req_t  req_o,
    input  logic      gnt_i,
    input  logic      rvalid_i,
    input  lane_vec_t rdata_i,
    output logic      beat_valid_o,
    output out_beat_t beat_o,
    input  logic      beat_ready_i
);

    out_cmd_t                cmd_q;
    logic                    busy_q;
    logic                    inflight_q;
    logic                    drain_q;
    logic                    last_pend_q;
    logic [`NPU_COUNT_W-1:0] rd_addr_q;

    assign cmd_ready_o = !busy_q;

    // one read in flight, issued only while the slice has room for it
    assign req_valid_o = busy_q && !inflight_q && !drain_q && beat_ready_i;

    always_comb begin
        req_o.we    = 1'b0;
        req_o.addr  = '{bank: cmd_q.bank, word: rd_addr_q[`NPU_ADDR_W-1:0]};
        req_o.wdata = '0;
    end

    // read data goes straight into the output slice
    assign beat_valid_o = rvalid_i;
    assign beat_o.data  = rdata_i;
    assign beat_o.last  = last_pend_q;

    always_ff @(posedge s00_axis_aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q      <= 1'b0;
            inflight_q  <= 1'b0;
            drain_q     <= 1'b0;
            last_pend_q <= 1'b0;
            rd_addr_q   <= '0;
        end else begin
            if (cmd_valid_i && cmd_ready_o) begin
                busy_q    <= 1'b1;
                rd_addr_q <= '0;
            end
            if (req_valid_o && gnt_i) begin
                inflight_q  <= 1'b1;
                last_pend_q <= (rd_addr_q + 1'b1 == cmd_q.count);
                rd_addr_q   <= rd_addr_q + 1'b1;
            end
            if (rvalid_i) begin
                inflight_q <= 1'b0;
                drain_q    <= last_pend_q;
            end
            // last beat sits in the slice until it leaves on the bus
            if (drain_q && beat_ready_i) begin
                busy_q  <= 1'b0;
                drain_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge s00_axis_aclk) begin
        if (cmd_valid_i && cmd_ready_o) begin
            cmd_q <= cmd_i;
        end
    end

    landing_has_room: assert property (@(posedge s00_axis_aclk) disable iff (!arst_n_i)
        rvalid_i |-> beat_ready_i);

endmodule

/* logic/npu_top.sv */
`timescale 1ns/10ps
`include "npu_consts.svh"

module npu_top import npu_pkg::*; (
    input  logic                   s00_axis_aclk,
    input  logic                   arst_n_i,
    input  logic [`NPU_WORD_W-1:0] s_axis_tdata_i,
    input  spad_addr_t             s_axis_tuser_i,
    input  logic                   s_axis_tvalid_i,
    output logic                   s_axis_tready_o,
    input  op_cmd_t                op_cmd_i,
    input  logic                   op_cmd_valid_i,
    output logic                   op_cmd_ready_o,
    output logic                   op_done_o,
    input  out_cmd_t               out_cmd_i,
    input  logic                   out_cmd_valid_i,
    output logic                   out_cmd_ready_o,
    output logic [`NPU_WORD_W-1:0] m_axis_tdata_o,
    output logic                   m_axis_tlast_o,
    output logic                   m_axis_tvalid_o,
    input  logic                   m_axis_tready_i
);

    in_beat_t                  ld_beat;
    logic                      ld_beat_valid;
    logic                      ld_beat_ready;
    out_beat_t                 st_beat;
    logic                      st_beat_valid;
    logic                      st_beat_ready;
    logic [`NPU_NUM_PORTS-1:0] req_valid;
    logic [`NPU_NUM_PORTS-1:0] gnt;
    logic [`NPU_NUM_PORTS-1:0] rvalid;
    mem_req_t                  req [`NPU_NUM_PORTS];
    lane_vec_t                 rdata;

    // ------------------------------------------------------------
    // input side
    // ------------------------------------------------------------
    axis_reg_slice #(.payload_t(in_beat_t)) in_slice_i (
        .s00_axis_aclk(s00_axis_aclk), .arst_n_i(arst_n_i),
        .in_valid_i(s_axis_tvalid_i), .in_data_i({s_axis_tdata_i, s_axis_tuser_i}),
        .in_ready_o(s_axis_tready_o),
        .out_valid_o(ld_beat_valid), .out_data_o(ld_beat), .out_ready_i(ld_beat_ready)
    );

    stream_loader loader_i (
        .s00_axis_aclk(s00_axis_aclk), .arst_n_i(arst_n_i),
        .beat_valid_i(ld_beat_valid), .beat_i(ld_beat), .beat_ready_o(ld_beat_ready),
        .req_valid_o(req_valid[PORT_LOAD]), .req_o(req[PORT_LOAD]), .gnt_i(gnt[PORT_LOAD])
    );

    eltwise_engine eltwise_i (
        .s00_axis_aclk(s00_axis_aclk), .arst_n_i(arst_n_i),
        .cmd_valid_i(op_cmd_valid_i), .cmd_i(op_cmd_i), .cmd_ready_o(op_cmd_ready_o),
        .done_o(op_done_o),
        .req_valid_o(req_valid[PORT_ELTWISE]), .req_o(req[PORT_ELTWISE]),
        .gnt_i(gnt[PORT_ELTWISE]), .rvalid_i(rvalid[PORT_ELTWISE]), .rdata_i(rdata)
    );

    // ------------------------------------------------------------
    // output side
    // ------------------------------------------------------------
    result_streamer streamer_i (
        .s00_axis_aclk(s00_axis_aclk), .arst_n_i(arst_n_i),
        .cmd_valid_i(out_cmd_valid_i), .cmd_i(out_cmd_i), .cmd_ready_o(out_cmd_ready_o),
        .req_valid_o(req_valid[PORT_STREAM]), .req_o(req[PORT_STREAM]),
        .gnt_i(gnt[PORT_STREAM]), .rvalid_i(rvalid[PORT_STREAM]), .rdata_i(rdata),
        .beat_valid_o(st_beat_valid), .beat_o(st_beat), .beat_ready_i(st_beat_ready)
    );

    axis_reg_slice #(.payload_t(out_beat_t)) out_slice_i (
        .s00_axis_aclk(s00_axis_aclk), .arst_n_i(arst_n_i),
        .in_valid_i(st_beat_valid), .in_data_i(st_beat), .in_ready_o(st_beat_ready),
        .out_valid_o(m_axis_tvalid_o), .out_data_o({m_axis_tdata_o, m_axis_tlast_o}),
        .out_ready_i(m_axis_tready_i)
    );

    scratchpad_arbiter spad_i (
        .s00_axis_aclk(s00_axis_aclk), .arst_n_i(arst_n_i),
        .req_valid_i(req_valid), .req_i(req), .gnt_o(gnt),
        .rvalid_o(rvalid), .rdata_o(rdata)
    );

endmodule

/* verification/npu_tb.sv */
`timescale 1ns/10ps
`include "npu_consts.svh"

module npu_tb import npu_pkg::*; ();

    localparam int WAIT_LIMIT = 2000;

    logic                   s00_axis_aclk;
    logic                   arst_n_i;
    logic [`NPU_WORD_W-1:0] s_axis_tdata_i;
    spad_addr_t             s_axis_tuser_i;
    logic                   s_axis_tvalid_i;
    logic                   s_axis_tready_o;
    op_cmd_t                op_cmd_i;
    logic                   op_cmd_valid_i;
    logic                   op_cmd_ready_o;
    logic                   op_done_o;
    out_cmd_t               out_cmd_i;
    logic                   out_cmd_valid_i;
    logic                   out_cmd_ready_o;
    logic [`NPU_WORD_W-1:0] m_axis_tdata_o;
    logic                   m_axis_tlast_o;
    logic                   m_axis_tvalid_o;
    logic                   m_axis_tready_i;

    integer seed;
    integer ready_seed;
    int     errors;
    int     err_start;
    int     tests_run;
    int     tests_failed;
    bit     abort;
    string  test_name;

    // reference scratchpad and expected output beats {data, last}
    logic [`NPU_WORD_W-1:0] model_mem [`NPU_NUM_BANKS][1 << `NPU_ADDR_W];
    logic [`NPU_WORD_W:0]   exp_mem [512];
    int                     exp_head;
    int                     exp_tail;
    logic [`NPU_WORD_W:0]   exp_beat;
    logic [`NPU_WORD_W:0]   got_beat;
    logic                   in_fire_q;
    logic                   op_fire_q;
    logic                   out_fire_q;
    logic                   op_pending;

    npu_top npu_top_i (.*);

    initial begin
        s00_axis_aclk = 1'b0;
        forever #50 s00_axis_aclk = ~s00_axis_aclk;
    end

    // ------------------------------------------------------------
    // handshake capture and expected-beat bookkeeping
    // ------------------------------------------------------------
    always @(posedge s00_axis_aclk) begin
        in_fire_q  <= s_axis_tvalid_i && s_axis_tready_o;
        op_fire_q  <= op_cmd_valid_i && op_cmd_ready_o;
        out_fire_q <= out_cmd_valid_i && out_cmd_ready_o;
        if (arst_n_i && m_axis_tvalid_o && m_axis_tready_i && exp_head != exp_tail) begin
            exp_head <= exp_head + 1;
        end
    end

    // a new command accepted on the done edge keeps the op pending
    always @(posedge s00_axis_aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            op_pending <= 1'b0;
        end else if (op_cmd_valid_i && op_cmd_ready_o) begin
            op_pending <= 1'b1;
        end else if (op_done_o) begin
            op_pending <= 1'b0;
        end
    end

    // output back-pressure, about one stall in four
    always @(negedge s00_axis_aclk) begin
        if (arst_n_i) begin
            m_axis_tready_i = ($random(ready_seed) & 3) != 0;
        end
    end

    assign exp_beat = exp_mem[exp_head];
    assign got_beat = {m_axis_tdata_o, m_axis_tlast_o};

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------
    reset_values: assert property (@(posedge s00_axis_aclk)
        $rose(arst_n_i) |-> !s_axis_tready_o && !m_axis_tvalid_o && !m_axis_tlast_o
            && !op_done_o && op_cmd_ready_o && out_cmd_ready_o && npu_top_i.gnt == '0)
        else begin
            errors++;
            $display("%s: control outputs do not hold their reset values", test_name);
        end

    beat_expected: assert property (@(posedge s00_axis_aclk) disable iff (!arst_n_i)
        m_axis_tvalid_o && m_axis_tready_i |-> exp_head != exp_tail)
        else begin
            errors++;
            $display("%s: output beat arrived with none expected", test_name);
        end

    beat_value: assert property (@(posedge s00_axis_aclk) disable iff (!arst_n_i)
        m_axis_tvalid_o && m_axis_tready_i && exp_head != exp_tail |-> got_beat == exp_beat)
        else begin
            errors++;
            $display("[ERROR] %s: expected %h, actual %h", test_name,
                     $sampled(exp_beat), $sampled(got_beat));
        end

    beat_held: assert property (@(posedge s00_axis_aclk) disable iff (!arst_n_i)
        m_axis_tvalid_o && !m_axis_tready_i |=> m_axis_tvalid_o
            && $stable(m_axis_tdata_o) && $stable(m_axis_tlast_o))
        else begin
            errors++;
            $display("%s: output beat changed while stalled", test_name);
        end

    done_once: assert property (@(posedge s00_axis_aclk) disable iff (!arst_n_i)
        op_done_o |-> op_pending)
        else begin
            errors++;
            $display("%s: done pulse without an accepted operation", test_name);
        end

    busy_not_ready: assert property (@(posedge s00_axis_aclk) disable iff (!arst_n_i)
        op_pending && !op_done_o |-> !op_cmd_ready_o)
        else begin
            errors++;
            $display("%s: command ready while an operation runs", test_name);
        end

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------
    function automatic logic [7:0] clamp_lane(input int v);
        if (v > 127) begin
            return 8'h7f;
        end
        if (v < -128) begin
            return 8'h80;
        end
        return v[7:0];
    endfunction

    function automatic logic [`NPU_WORD_W-1:0] apply_op(input eltwise_op_e op,
            input logic [`NPU_WORD_W-1:0] a, input logic [`NPU_WORD_W-1:0] b);
        logic [`NPU_WORD_W-1:0] r;
        int                     x;
        int                     y;
        for (int l = 0; l < `NPU_LANES; l++) begin
            x = $signed(a[`NPU_LANE_W*l +: `NPU_LANE_W]);
            y = $signed(b[`NPU_LANE_W*l +: `NPU_LANE_W]);
            case (op)
                OP_ADD:  r[`NPU_LANE_W*l +: `NPU_LANE_W] = clamp_lane(x + y);
                OP_SUB:  r[`NPU_LANE_W*l +: `NPU_LANE_W] = clamp_lane(x - y);
                default: r[`NPU_LANE_W*l +: `NPU_LANE_W] = clamp_lane(x * y);
            endcase
        end
        return r;
    endfunction

    function automatic logic [`NPU_WORD_W-1:0] rand_word();
        return {$random(seed), $random(seed)};
    endfunction

    // ------------------------------------------------------------
    // stimulus, every task starts and ends on a falling edge
    // ------------------------------------------------------------
    task automatic report_timeout(input string what);
        errors++;
        abort = 1'b1;
        $display("%s: timed out waiting for %s", test_name, what);
    endtask

    task automatic load_word(input logic [`NPU_BANK_W-1:0] bank,
            input logic [`NPU_ADDR_W-1:0] addr, input logic [`NPU_WORD_W-1:0] data);
        int t;
        if (abort) return;
        s_axis_tdata_i  = data;
        s_axis_tuser_i  = '{bank: bank, word: addr};
        s_axis_tvalid_i = 1'b1;
        t = 0;
        do begin
            @(negedge s00_axis_aclk);
            t++;
        end while (!in_fire_q && t < WAIT_LIMIT);
        s_axis_tvalid_i = 1'b0;
        if (in_fire_q) begin
            model_mem[bank][addr] = data;
        end else begin
            report_timeout("input beat accept");
        end
    endtask

    task automatic issue_op(input eltwise_op_e op, input logic [`NPU_BANK_W-1:0] a,
            input logic [`NPU_BANK_W-1:0] b, input logic [`NPU_BANK_W-1:0] d, input int count);
        int t;
        if (abort) return;
        op_cmd_i       = '{op: op, src_a: a, src_b: b, dst: d, count: count[`NPU_COUNT_W-1:0]};
        op_cmd_valid_i = 1'b1;
        t = 0;
        do begin
            @(negedge s00_axis_aclk);
            t++;
        end while (!op_fire_q && t < WAIT_LIMIT);
        op_cmd_valid_i = 1'b0;
        if (!op_fire_q) begin
            report_timeout("operation command accept");
            return;
        end
        for (int i = 0; i < count; i++) begin
            model_mem[d][i] = apply_op(op, model_mem[a][i], model_mem[b][i]);
        end
    endtask

    task automatic wait_op_done();
        int t;
        if (abort) return;
        t = 0;
        while (!op_done_o && t < WAIT_LIMIT) begin
            @(negedge s00_axis_aclk);
            t++;
        end
        if (!op_done_o) begin
            report_timeout("operation done");
        end
    endtask

    task automatic read_bank(input logic [`NPU_BANK_W-1:0] bank, input int count);
        int t;
        if (abort) return;
        for (int i = 0; i < count; i++) begin
            exp_mem[exp_tail] = {model_mem[bank][i], i == count - 1};
            exp_tail++;
        end
        out_cmd_i       = '{bank: bank, count: count[`NPU_COUNT_W-1:0]};
        out_cmd_valid_i = 1'b1;
        t = 0;
        do begin
            @(negedge s00_axis_aclk);
            t++;
        end while (!out_fire_q && t < WAIT_LIMIT);
        out_cmd_valid_i = 1'b0;
        if (!out_fire_q) begin
            report_timeout("readout command accept");
            return;
        end
        t = 0;
        while ((exp_head != exp_tail || !out_cmd_ready_o) && t < WAIT_LIMIT) begin
            @(negedge s00_axis_aclk);
            t++;
        end
        if (exp_head != exp_tail || !out_cmd_ready_o) begin
            report_timeout("readout to drain");
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_start = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == err_start) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, errors - err_start);
        end
    endtask

    initial begin
        s_axis_tdata_i  = '0;
        s_axis_tuser_i  = '0;
        s_axis_tvalid_i = 1'b0;
        op_cmd_i        = '0;
        op_cmd_valid_i  = 1'b0;
        out_cmd_i       = '0;
        out_cmd_valid_i = 1'b0;
        m_axis_tready_i = 1'b0;
        arst_n_i        = 1'b0;
        seed            = 32'h060696dd;
        ready_seed      = seed ^ 32'h1;
        errors          = 0;
        tests_run       = 0;
        tests_failed    = 0;
        exp_head        = 0;
        exp_tail        = 0;
        abort           = 1'b0;
        test_name       = "reset_state";
        repeat (4) @(negedge s00_axis_aclk);
        arst_n_i = 1'b1;

        start_test("reset_state");
        @(negedge s00_axis_aclk);
        end_test();

        // lane pairs that overflow both ways under add, sub and mul
        start_test("load_readout");
        load_word(0, 0, 64'h7f80_7f80_40c0_01ff);
        load_word(0, 1, 64'h7f80_0a80_7ff6_c8c8);
        load_word(1, 0, 64'h01ff_7f80_40c0_ff01);
        load_word(1, 1, 64'h807f_f67f_80f6_c838);
        for (int i = 2; i < 8; i++) begin
            load_word(0, i, rand_word());
            load_word(1, i, rand_word());
        end
        read_bank(0, 8);
        read_bank(1, 8);
        end_test();

        start_test("add");
        issue_op(OP_ADD, 0, 1, 2, 8);
        wait_op_done();
        read_bank(2, 8);
        end_test();

        start_test("sub_mul");
        issue_op(OP_SUB, 0, 1, 3, 8);
        wait_op_done();
        read_bank(3, 8);
        issue_op(OP_MUL, 0, 1, 2, 8);
        wait_op_done();
        read_bank(2, 8);
        end_test();

        // second command waits on the first one's done
        start_test("handshake");
        issue_op(OP_ADD, 1, 0, 3, 4);
        issue_op(OP_SUB, 1, 0, 2, 8);
        wait_op_done();
        read_bank(3, 4);
        read_bank(2, 8);
        end_test();

        start_test("contention");
        fork
            begin
                for (int i = 0; i < 16; i++) begin
                    load_word(3, i, rand_word());
                end
            end
            begin
                issue_op(OP_MUL, 0, 1, 2, 8);
                wait_op_done();
            end
            read_bank(1, 8);
        join
        read_bank(2, 8);
        read_bank(3, 16);
        end_test();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+logic
logic/npu_pkg.sv
logic/axis_reg_slice.sv
logic/scratchpad_arbiter.sv
logic/stream_loader.sv
logic/eltwise_engine.sv
logic/result_streamer.sv
logic/npu_top.sv
verification/npu_tb.sv

/* Bender.yml */
package:
  name: npu_datapath

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/npu_pkg.sv
      - logic/axis_reg_slice.sv
      - logic/scratchpad_arbiter.sv
      - logic/stream_loader.sv
      - logic/eltwise_engine.sv
      - logic/result_streamer.sv
      - logic/npu_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verification/npu_tb.sv
